// File: logic/gf_arbiter.sv
`timescale 1ns/1ps

module gf_arbiter (
	input logic clk,
	input logic reset,
	gf_bus_if.arbiter mul_bus,
	gf_bus_if.arbiter inv_bus,
	output logic rf_we,
	output gf_pkg::reg_addr_t rf_addr,
	output gf_pkg::gf_elem_t rf_wdata,
	input gf_pkg::gf_elem_t rf_rdata
);

	logic last_inv; // inversion engine won the last grant.

	// ******************************
	// round robin grant
	// ******************************

	// on a tie the engine that lost last time goes first.
	assign mul_bus.gnt = mul_bus.req && (!inv_bus.req || last_inv);
	assign inv_bus.gnt = inv_bus.req && (!mul_bus.req || !last_inv);

	always_ff @(posedge clk) begin
		if (reset)
			last_inv <= 1'b0;
		else if (mul_bus.gnt)
			last_inv <= 1'b0;
		else if (inv_bus.gnt)
			last_inv <= 1'b1;
	end

	// ******************************
	// register file port mux
	// ******************************

	assign rf_we = (mul_bus.gnt && mul_bus.we) || (inv_bus.gnt && inv_bus.we);
	assign rf_addr = inv_bus.gnt ? inv_bus.addr : mul_bus.addr;
	assign rf_wdata = inv_bus.gnt ? inv_bus.wdata : mul_bus.wdata;

	// read data belongs to whoever was granted last cycle.
	assign mul_bus.rdata = rf_rdata;
	assign inv_bus.rdata = rf_rdata;

endmodule

// File: logic/gf_bus_if.sv
`timescale 1ns/1ps

interface gf_bus_if;

	logic req;
	logic we;
	gf_pkg::reg_addr_t addr;
	gf_pkg::gf_elem_t wdata;
	logic gnt;
	gf_pkg::gf_elem_t rdata; // registered, one cycle behind gnt.

	modport requester (
		output req, we, addr, wdata,
		input gnt, rdata
	);

	modport arbiter (
		input req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

// File: logic/gf_coprocessor.sv
`timescale 1ns/1ps

module gf_coprocessor (
	input logic clk,
	input logic reset,
	input logic host_we,
	input gf_pkg::reg_addr_t host_waddr,
	input gf_pkg::gf_elem_t host_wdata,
	input gf_pkg::reg_addr_t host_raddr,
	output gf_pkg::gf_elem_t host_rdata,
	input logic mul_start,
	input gf_pkg::mul_op_t mul_op,
	input gf_pkg::reg_addr_t mul_src_a,
	input gf_pkg::reg_addr_t mul_src_b,
	input gf_pkg::reg_addr_t mul_dst,
	output logic mul_busy,
	output logic mul_done,
	input logic inv_start,
	input gf_pkg::reg_addr_t inv_src,
	input gf_pkg::reg_addr_t inv_dst,
	output logic inv_busy,
	output logic inv_done
);

	logic rf_we;
	gf_pkg::reg_addr_t rf_addr;
	gf_pkg::gf_elem_t rf_wdata;
	gf_pkg::gf_elem_t rf_rdata;

	gf_bus_if mul_bus ();
	gf_bus_if inv_bus ();

	// ******************************
	// engines
	// ******************************

	gf_mul_engine u_mul (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.op(mul_op),
		.src_a(mul_src_a),
		.src_b(mul_src_b),
		.dst(mul_dst),
		.busy(mul_busy),
		.done(mul_done),
		.bus(mul_bus.requester)
	);

	gf_inv_engine u_inv (
		.clk(clk),
		.reset(reset),
		.start(inv_start),
		.src(inv_src),
		.dst(inv_dst),
		.busy(inv_busy),
		.done(inv_done),
		.bus(inv_bus.requester)
	);

	// ******************************
	// shared register file
	// ******************************

	gf_arbiter u_arb (
		.clk(clk),
		.reset(reset),
		.mul_bus(mul_bus.arbiter),
		.inv_bus(inv_bus.arbiter),
		.rf_we(rf_we),
		.rf_addr(rf_addr),
		.rf_wdata(rf_wdata),
		.rf_rdata(rf_rdata)
	);

	gf_regfile u_rf (
		.clk(clk),
		.reset(reset),
		.bus_we(rf_we),
		.bus_addr(rf_addr),
		.bus_wdata(rf_wdata),
		.bus_rdata(rf_rdata),
		.host_we(host_we),
		.host_waddr(host_waddr),
		.host_raddr(host_raddr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata)
	);

endmodule

// File: logic/gf_inv_engine.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_inv_engine (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_pkg::reg_addr_t src,
	input gf_pkg::reg_addr_t dst,
	output logic busy,
	output logic done,
	gf_bus_if.requester bus
);

	localparam int STEP_W = $clog2(`GF_M);

	gf_pkg::inv_state_t state;
	gf_pkg::reg_addr_t src_q, dst_q;
	gf_pkg::gf_elem_t sq_q; // a^(2^k).
	gf_pkg::gf_elem_t acc_q; // running product.
	logic [STEP_W-1:0] step;

	// ******************************
	// control
	// ******************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gf_pkg::IS_IDLE;
			done <= 1'b0;
			step <= '0;
		end else begin
			done <= 1'b0;
			case (state)
			gf_pkg::IS_IDLE: if (start) state <= gf_pkg::IS_RD;
			gf_pkg::IS_RD: if (bus.gnt) state <= gf_pkg::IS_LOAD;
			gf_pkg::IS_LOAD: begin
				state <= gf_pkg::IS_STEP;
				step <= STEP_W'(`GF_M - 1); // one step per power a^2 .. a^(2^(M-1)).
			end
			gf_pkg::IS_STEP: begin
				step <= step - 1'b1;
				if (step == 1)
					state <= gf_pkg::IS_WR;
			end
			gf_pkg::IS_WR: if (bus.gnt) begin
				state <= gf_pkg::IS_IDLE;
				done <= 1'b1;
			end
			default: state <= gf_pkg::IS_IDLE;
			endcase
		end
	end

	// ******************************
	// square and multiply
	// ******************************

	// a^(2^M - 2) = a^2 * a^4 * ... * a^(2^(M-1)); zero stays zero.
	always_ff @(posedge clk) begin
		if (state == gf_pkg::IS_IDLE && start) begin
			src_q <= src;
			dst_q <= dst;
		end
		case (state)
		gf_pkg::IS_LOAD: begin
			sq_q <= gf_pkg::gf_mul(bus.rdata, bus.rdata);
			acc_q <= gf_pkg::gf_elem_t'(1);
		end
		gf_pkg::IS_STEP: begin
			acc_q <= gf_pkg::gf_mul(acc_q, sq_q);
			sq_q <= gf_pkg::gf_mul(sq_q, sq_q);
		end
		default: ;
		endcase
	end

	assign busy = (state != gf_pkg::IS_IDLE);

	assign bus.req = (state == gf_pkg::IS_RD) || (state == gf_pkg::IS_WR);
	assign bus.we = (state == gf_pkg::IS_WR);
	assign bus.addr = (state == gf_pkg::IS_RD) ? src_q : dst_q;
	assign bus.wdata = acc_q;

endmodule

// File: logic/gf_mul_engine.sv
`timescale 1ns/1ps

module gf_mul_engine (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_pkg::mul_op_t op,
	input gf_pkg::reg_addr_t src_a,
	input gf_pkg::reg_addr_t src_b,
	input gf_pkg::reg_addr_t dst,
	output logic busy,
	output logic done,
	gf_bus_if.requester bus
);

	gf_pkg::mul_state_t state;
	gf_pkg::mul_op_t op_q;
	gf_pkg::reg_addr_t src_a_q, src_b_q, dst_q;
	gf_pkg::gf_elem_t a_q;
	gf_pkg::gf_elem_t b_q; // holds a^2 for a cube.
	gf_pkg::gf_elem_t res_q;
	logic a_cap; // rdata carries operand a this cycle.

	// ******************************
	// control
	// ******************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gf_pkg::MS_IDLE;
			done <= 1'b0;
			a_cap <= 1'b0;
		end else begin
			done <= 1'b0;
			a_cap <= (state == gf_pkg::MS_RD_A) && bus.gnt;
			case (state)
			gf_pkg::MS_IDLE: if (start) state <= gf_pkg::MS_RD_A;
			gf_pkg::MS_RD_A: if (bus.gnt)
				state <= (op_q == gf_pkg::MUL_CUBE) ? gf_pkg::MS_SQ : gf_pkg::MS_RD_B;
			gf_pkg::MS_RD_B: if (bus.gnt) state <= gf_pkg::MS_CALC;
			gf_pkg::MS_SQ: state <= gf_pkg::MS_CALC;
			gf_pkg::MS_CALC: state <= gf_pkg::MS_WR;
			gf_pkg::MS_WR: if (bus.gnt) begin
				state <= gf_pkg::MS_IDLE;
				done <= 1'b1;
			end
			default: state <= gf_pkg::MS_IDLE;
			endcase
		end
	end

	// ******************************
	// datapath
	// ******************************

	always_ff @(posedge clk) begin
		if (state == gf_pkg::MS_IDLE && start) begin
			op_q <= op;
			src_a_q <= src_a;
			src_b_q <= src_b;
			dst_q <= dst;
		end
		if (a_cap)
			a_q <= bus.rdata;
		if (state == gf_pkg::MS_SQ)
			b_q <= gf_pkg::gf_mul(bus.rdata, bus.rdata);
		// b comes straight off the bus for a plain product.
		if (state == gf_pkg::MS_CALC)
			res_q <= gf_pkg::gf_mul(a_q, (op_q == gf_pkg::MUL_CUBE) ? b_q : bus.rdata);
	end

	assign busy = (state != gf_pkg::MS_IDLE);

	assign bus.req = (state == gf_pkg::MS_RD_A) || (state == gf_pkg::MS_RD_B) ||
		(state == gf_pkg::MS_WR);
	assign bus.we = (state == gf_pkg::MS_WR);
	assign bus.addr = (state == gf_pkg::MS_RD_A) ? src_a_q :
		(state == gf_pkg::MS_RD_B) ? src_b_q : dst_q;
	assign bus.wdata = res_q;

endmodule

// File: logic/gf_params.svh
`ifndef GF_PARAMS_SVH
`define GF_PARAMS_SVH

// field is GF(2^4) over x^4 + x + 1.
`define GF_M 4

// low terms of the polynomial, x^4 left implicit.
`define GF_POLY 4'b0011

`define GF_REGS 8

`endif

// File: logic/gf_pkg.sv
`include "gf_params.svh"

package gf_pkg;

	typedef logic [`GF_M-1:0] gf_elem_t;
	typedef logic [$clog2(`GF_REGS)-1:0] reg_addr_t;

	typedef enum logic {
		MUL_AB,
		MUL_CUBE
	} mul_op_t;

	typedef enum logic [2:0] {
		MS_IDLE,
		MS_RD_A,
		MS_RD_B,
		MS_SQ,
		MS_CALC,
		MS_WR
	} mul_state_t;

	typedef enum logic [2:0] {
		IS_IDLE,
		IS_RD,
		IS_LOAD,
		IS_STEP,
		IS_WR
	} inv_state_t;

	// ******************************
	// standard basis arithmetic
	// ******************************

	// x * alpha, top bit folded back through the polynomial.
	function automatic gf_elem_t gf_mul_alpha(gf_elem_t x);
		return {x[`GF_M-2:0], 1'b0} ^ (x[`GF_M-1] ? gf_elem_t'(`GF_POLY) : gf_elem_t'(0));
	endfunction

	// one row per bit of b, row i is a * alpha^i.
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t row;
		gf_elem_t acc;
		row = a;
		acc = '0;
		for (int i = 0; i < `GF_M; i++) begin
			acc = acc ^ (row & {`GF_M{b[i]}}); // masked row.
			row = gf_mul_alpha(row);
		end
		return acc;
	endfunction

endpackage

// File: logic/gf_regfile.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_regfile (
	input logic clk,
	input logic reset,
	input logic bus_we,
	input gf_pkg::reg_addr_t bus_addr,
	input gf_pkg::gf_elem_t bus_wdata,
	output gf_pkg::gf_elem_t bus_rdata,
	input logic host_we,
	input gf_pkg::reg_addr_t host_waddr,
	input gf_pkg::reg_addr_t host_raddr,
	input gf_pkg::gf_elem_t host_wdata,
	output gf_pkg::gf_elem_t host_rdata
);

	gf_pkg::gf_elem_t regs [`GF_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `GF_REGS; i++)
				regs[i] <= '0;
			bus_rdata <= '0;
			host_rdata <= '0;
		end else begin
			if (host_we)
				regs[host_waddr] <= host_wdata;
			if (bus_we)
				regs[bus_addr] <= bus_wdata; // engine write wins a collision.
			bus_rdata <= regs[bus_addr];
			host_rdata <= regs[host_raddr];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
rm -rf obj_dir
verilator --binary --assert --top-module gf_tb -f sources.f -o gf_sim
./obj_dir/gf_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

// File: sources.f
+incdir+logic
logic/gf_pkg.sv
logic/gf_bus_if.sv
logic/gf_regfile.sv
logic/gf_arbiter.sv
logic/gf_mul_engine.sv
logic/gf_inv_engine.sv
logic/gf_coprocessor.sv
tests/gf_clock.sv
tests/gf_assertions.sv
tests/gf_tb.sv

// File: tests/gf_assertions.sv
`timescale 1ns/1ps

module gf_assertions (
	input logic clk,
	input logic reset,
	input logic gnt_a,
	input logic gnt_b,
	input logic busy,
	input logic done
);

	// one register file port, so one grant per cycle.
	gnt_exclusive: assert property (@(posedge clk) disable iff (reset) !(gnt_a && gnt_b))
		else $error("both bus grants high in one cycle");

	done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done held for more than one cycle");

	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy && !done)
		else $error("busy or done high in the first cycle after reset");

endmodule

bind gf_arbiter gf_assertions arb_checks (
	.clk(clk),
	.reset(reset),
	.gnt_a(mul_bus.gnt),
	.gnt_b(inv_bus.gnt),
	.busy(1'b0),
	.done(1'b0)
);

bind gf_mul_engine gf_assertions mul_checks (
	.clk(clk),
	.reset(reset),
	.gnt_a(1'b0),
	.gnt_b(1'b0),
	.busy(busy),
	.done(done)
);

bind gf_inv_engine gf_assertions inv_checks (
	.clk(clk),
	.reset(reset),
	.gnt_a(1'b0),
	.gnt_b(1'b0),
	.busy(busy),
	.done(done)
);

// File: tests/gf_clock.sv
`timescale 1ns/1ps

module gf_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk; // 8 ns period.

endmodule

// File: tests/gf_tb.sv
`timescale 1ns/1ps

module gf_tb;

	localparam int OP_LOAD = 1;
	localparam int OP_MUL = 2;
	localparam int OP_CUBE = 3;
	localparam int OP_INV = 4;
	localparam int OP_BOTH = 5;

	logic clk;
	logic reset;
	logic host_we;
	gf_pkg::reg_addr_t host_waddr;
	gf_pkg::gf_elem_t host_wdata;
	gf_pkg::reg_addr_t host_raddr;
	gf_pkg::gf_elem_t host_rdata;
	logic mul_start;
	gf_pkg::mul_op_t mul_op;
	gf_pkg::reg_addr_t mul_src_a;
	gf_pkg::reg_addr_t mul_src_b;
	gf_pkg::reg_addr_t mul_dst;
	logic mul_busy;
	logic mul_done;
	logic inv_start;
	gf_pkg::reg_addr_t inv_src;
	gf_pkg::reg_addr_t inv_dst;
	logic inv_busy;
	logic inv_done;

	// one entry per data line.
	int line_op[$];
	logic [3:0] line_a[$];
	logic [3:0] line_b[$];
	logic [3:0] line_r1[$];
	logic [3:0] line_r2[$];

	int cycle_count;
	int cycle_limit;
	logic [31:0] rng_state;
	logic [3:0] alog [15]; // alpha^i.
	logic [3:0] vlog [16]; // discrete log, entry 0 unused.
	gf_pkg::reg_addr_t ra;
	gf_pkg::reg_addr_t rb;
	gf_pkg::reg_addr_t rd;
	gf_pkg::reg_addr_t rx;

	gf_clock u_clock (.clk(clk));

	gf_coprocessor dut (.*);

	// ******************************
	// helpers
	// ******************************

	task automatic fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [7:0] got, logic [7:0] expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
			fail_run();
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1; // inputs change just after the edge.
	endtask

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// log tables from x^4 + x + 1 by repeated doubling.
	task automatic build_tables();
		logic [4:0] v;
		v = 5'h01;
		for (int i = 0; i < 15; i++) begin
			alog[4'(i)] = v[3:0];
			vlog[v[3:0]] = 4'(i);
			v = {v[3:0], 1'b0};
			if (v[4])
				v = v ^ 5'h13;
		end
		vlog[0] = 4'h0;
	endtask

	function automatic logic [3:0] field_product(logic [3:0] x, logic [3:0] y);
		int e;
		if (x == 4'h0 || y == 4'h0)
			return 4'h0;
		e = (int'(vlog[x]) + int'(vlog[y])) % 15;
		return alog[4'(e)];
	endfunction

	function automatic int op_code(logic [63:0] word);
		case (word)
		64'("LOAD"): return OP_LOAD;
		64'("MUL"): return OP_MUL;
		64'("CUBE"): return OP_CUBE;
		64'("INV"): return OP_INV;
		64'("BOTH"): return OP_BOTH;
		default: return 0;
		endcase
	endfunction

	task automatic read_testdata();
		int fd;
		int n;
		int code;
		string line;
		logic [63:0] word;
		logic [7:0] a, b, r1, r2;
		fd = $fopen("tests/gf_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/gf_testdata.txt");
			fail_run();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h", word, a, b, r1, r2);
			code = op_code(word);
			if (n != 5 || code == 0) begin
				$display("bad test data line: %s", line);
				fail_run();
			end
			line_op.push_back(code);
			line_a.push_back(a[3:0]);
			line_b.push_back(b[3:0]);
			line_r1.push_back(r1[3:0]);
			line_r2.push_back(r2[3:0]);
		end
		$fclose(fd);
	endtask

	// four distinct registers per operation.
	task automatic pick_regs();
		logic [7:0] used;
		gf_pkg::reg_addr_t picks [4];
		used = '0;
		for (int k = 0; k < 4; k++) begin
			do begin
				rng_state = xorshift(rng_state);
				picks[k] = rng_state[10:8];
			end while (used[picks[k]]);
			used[picks[k]] = 1'b1;
		end
		ra = picks[0];
		rb = picks[1];
		rd = picks[2];
		rx = picks[3];
	endtask

	task automatic host_write(gf_pkg::reg_addr_t addr, gf_pkg::gf_elem_t value);
		host_we = 1'b1;
		host_waddr = addr;
		host_wdata = value;
		tick();
		host_we = 1'b0;
	endtask

	task automatic host_read(gf_pkg::reg_addr_t addr, output gf_pkg::gf_elem_t value);
		host_raddr = addr;
		tick(); // registered read.
		value = host_rdata;
	endtask

	// ******************************
	// operations
	// ******************************

	task automatic run_load(logic [3:0] a);
		gf_pkg::gf_elem_t v;
		logic [3:0] fill;
		for (int i = 0; i < 8; i++) begin
			fill = a + 4'(i);
			host_write(3'(i), fill);
		end
		for (int i = 0; i < 8; i++) begin
			fill = a + 4'(i);
			host_read(3'(i), v);
			check_value("host_rdata", 8'(v), 8'(fill));
		end
	endtask

	task automatic run_mul(gf_pkg::mul_op_t op, logic [3:0] a, logic [3:0] b,
		logic [3:0] expected);
		int t_start;
		int extra;
		gf_pkg::gf_elem_t guard;
		gf_pkg::gf_elem_t v;
		pick_regs();
		guard = ~expected;
		host_write(ra, a);
		host_write(rb, b);
		host_write(rd, guard);
		host_write(rx, guard);
		mul_op = op;
		mul_src_a = ra;
		mul_src_b = rb;
		mul_dst = rd;
		mul_start = 1'b1;
		t_start = cycle_count;
		tick();
		mul_start = 1'b0;
		tick();
		// second start while busy, aimed at rx.
		check_value("mul_busy", 8'(mul_busy), 8'h01);
		mul_op = gf_pkg::MUL_AB;
		mul_dst = rx;
		mul_start = 1'b1;
		tick();
		mul_start = 1'b0;
		while (!mul_done)
			tick();
		check_value("mul_done latency", 8'(cycle_count - t_start), 8'h05);
		check_value("mul_busy", 8'(mul_busy), 8'h00); // falls with done.
		extra = 0;
		repeat (10) begin
			tick();
			if (mul_done)
				extra++;
		end
		check_value("mul_done extra pulses", 8'(extra), 8'h00);
		host_read(rd, v);
		check_value("host_rdata (dst)", 8'(v), 8'(expected));
		host_read(rx, v);
		check_value("host_rdata (ignored dst)", 8'(v), 8'(guard));
	endtask

	task automatic run_inv(logic [3:0] a, logic [3:0] expected);
		gf_pkg::gf_elem_t v;
		pick_regs();
		host_write(ra, a);
		host_write(rd, ~expected);
		inv_src = ra;
		inv_dst = rd;
		inv_start = 1'b1;
		tick();
		inv_start = 1'b0;
		check_value("inv_busy", 8'(inv_busy), 8'h01);
		while (!inv_done)
			tick();
		check_value("inv_busy", 8'(inv_busy), 8'h00); // falls with done.
		host_read(rd, v);
		check_value("host_rdata (dst)", 8'(v), 8'(expected));
		// stated inverse must multiply back to one.
		if (a == 4'h0)
			check_value("inverse of zero", 8'(expected), 8'h00);
		else
			check_value("a times inverse", 8'(field_product(a, expected)), 8'h01);
	endtask

	task automatic run_both(logic [3:0] a, logic [3:0] b, logic [3:0] exp_mul,
		logic [3:0] exp_inv);
		logic seen_mul;
		logic seen_inv;
		gf_pkg::gf_elem_t v;
		pick_regs();
		host_write(ra, a);
		host_write(rb, b);
		host_write(rd, ~exp_mul);
		host_write(rx, ~exp_inv);
		mul_op = gf_pkg::MUL_AB;
		mul_src_a = ra;
		mul_src_b = rb;
		mul_dst = rd;
		inv_src = rb;
		inv_dst = rx;
		mul_start = 1'b1;
		inv_start = 1'b1;
		tick();
		mul_start = 1'b0;
		inv_start = 1'b0;
		seen_mul = 1'b0;
		seen_inv = 1'b0;
		while (!(seen_mul && seen_inv)) begin
			tick();
			if (mul_done)
				seen_mul = 1'b1;
			if (inv_done)
				seen_inv = 1'b1;
		end
		host_read(rd, v);
		check_value("host_rdata (mul dst)", 8'(v), 8'(exp_mul));
		host_read(rx, v);
		check_value("host_rdata (inv dst)", 8'(v), 8'(exp_inv));
	endtask

	// ******************************
	// main sequence and timeout
	// ******************************

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			fail_run();
		end
	end

	initial begin
		gf_pkg::gf_elem_t v;
		reset = 1'b1;
		host_we = 1'b0;
		host_waddr = '0;
		host_wdata = '0;
		host_raddr = '0;
		mul_start = 1'b0;
		mul_op = gf_pkg::MUL_AB;
		mul_src_a = '0;
		mul_src_b = '0;
		mul_dst = '0;
		inv_start = 1'b0;
		inv_src = '0;
		inv_dst = '0;
		cycle_count = 0;
		cycle_limit = 100;
		rng_state = 32'd53;
		build_tables();
		read_testdata();
		cycle_limit = 40 * line_op.size() + 100;
		repeat (8) tick();
		reset = 1'b0;
		for (int i = 0; i < 8; i++) begin
			host_read(3'(i), v); // cleared by reset.
			check_value("host_rdata after reset", 8'(v), 8'h00);
		end
		foreach (line_op[i]) begin
			case (line_op[i])
			OP_LOAD: run_load(line_a[i]);
			OP_MUL: run_mul(gf_pkg::MUL_AB, line_a[i], line_b[i], line_r1[i]);
			OP_CUBE: run_mul(gf_pkg::MUL_CUBE, line_a[i], line_a[i], line_r1[i]);
			OP_INV: run_inv(line_a[i], line_r1[i]);
			default: run_both(line_a[i], line_b[i], line_r1[i], line_r2[i]);
			endcase
		end
		$display("No errors");
		$finish;
	end

endmodule

// File: tests/gf_testdata.txt
# columns: op a b r1 r2, all hex. MUL r1 = a*b, CUBE r1 = a^3, INV r1 = 1/a,
# BOTH r1 = a*b and r2 = 1/b, LOAD fills register i with a+i.
LOAD 5 0 0 0
LOAD a 0 0 0
MUL 3 7 9 0
MUL 2 9 1 0
MUL 5 6 d 0
MUL a b 2 0
MUL f f a 0
MUL 0 7 0 0
CUBE 0 0 0 0
CUBE 1 0 1 0
CUBE 2 0 8 0
CUBE 3 0 f 0
CUBE e 0 8 0
INV 0 0 0 0
INV 1 0 1 0
INV 2 0 9 0
INV b 0 5 0
INV f 0 8 0
BOTH 3 7 9 6
BOTH 5 6 d 7
BOTH b d 6 4
BOTH 0 9 0 2
